//--- rtl/ldq_pkg.sv
package ldq_pkg;

  // --------------------------------------------------------------------------
  // queue geometry
  // --------------------------------------------------------------------------
  localparam int LDQ_SIZE  = 8;
  localparam int DISP_SIZE = 2;          // loads accepted per cycle
  localparam int LDQ_IDX_W = $clog2(LDQ_SIZE);
  localparam int CMT_ID_W  = 6;
  localparam int VADDR_W   = 16;

  // --------------------------------------------------------------------------
  // vector types
  // --------------------------------------------------------------------------
  typedef logic [LDQ_IDX_W-1:0] ldq_idx_t;
  typedef logic [LDQ_SIZE-1:0]  ldq_oh_t;    // one bit per entry
  typedef logic [LDQ_IDX_W:0]   ldq_cnt_t;   // 0 .. LDQ_SIZE
  typedef logic [CMT_ID_W-1:0]  cmt_id_t;
  typedef logic [VADDR_W-1:0]   vaddr_t;

  // per-entry life cycle
  // free -> wait issue -> issued -> (store hazard ->) done -> wait commit
  typedef enum logic [2:0] {
    LDQ_INIT          = 3'd0,
    LDQ_ISSUE_WAIT    = 3'd1,
    LDQ_ISSUED        = 3'd2,
    LDQ_STQ_HAZ       = 3'd3,
    LDQ_EX3_DONE      = 3'd4,
    LDQ_WAIT_COMPLETE = 3'd5
  } ldq_state_t;

endpackage

//--- rtl/ldq_alloc.sv
`timescale 1ns/1ps

module ldq_alloc (
  input  logic                          i_clk,
  input  logic                          i_reset_n,
  input  logic [ldq_pkg::DISP_SIZE-1:0] i_disp_valid,
  input  logic                          i_flush,
  input  ldq_pkg::ldq_oh_t              i_entry_valid,
  input  ldq_pkg::ldq_oh_t              i_entry_finish,
  output ldq_pkg::ldq_idx_t             o_in_ptr,
  output ldq_pkg::ldq_idx_t             o_out_ptr,
  output logic                          o_credit_return_valid,
  output ldq_pkg::ldq_cnt_t             o_credit_return_val
);

  ldq_pkg::ldq_idx_t r_in_ptr;
  ldq_pkg::ldq_idx_t r_out_ptr;
  ldq_pkg::ldq_idx_t w_out_ptr_nxt;
  ldq_pkg::ldq_cnt_t w_disp_num;
  ldq_pkg::ldq_cnt_t w_valid_cnt;
  ldq_pkg::ldq_cnt_t w_free_cnt;
  logic              w_finish;
  logic              r_credit_valid;
  ldq_pkg::ldq_cnt_t r_credit_val;

  assign w_disp_num    = ldq_pkg::ldq_cnt_t'($countones(i_disp_valid));
  assign w_valid_cnt   = ldq_pkg::ldq_cnt_t'($countones(i_entry_valid));
  assign w_free_cnt    = ldq_pkg::ldq_cnt_t'(ldq_pkg::LDQ_SIZE) - w_valid_cnt;
  assign w_finish      = |i_entry_finish;
  assign w_out_ptr_nxt = r_out_ptr + ldq_pkg::ldq_idx_t'(w_finish);  // in order retire

  always_ff @(posedge i_clk) begin
    if (i_reset_n) begin
      r_in_ptr       <= '0;
      r_out_ptr      <= '0;
      r_credit_valid <= 1'b0;
      r_credit_val   <= '0;
    end else begin
      r_out_ptr <= w_out_ptr_nxt;
      if (i_flush) begin
        // every live entry dies, queue becomes empty
        r_in_ptr       <= w_out_ptr_nxt;
        r_credit_valid <= |i_entry_valid;
        r_credit_val   <= w_valid_cnt;
      end else begin
        r_in_ptr       <= r_in_ptr + ldq_pkg::ldq_idx_t'(w_disp_num);
        r_credit_valid <= w_finish;
        r_credit_val   <= ldq_pkg::ldq_cnt_t'(w_finish);
      end
    end
  end

  assign o_in_ptr              = r_in_ptr;
  assign o_out_ptr             = r_out_ptr;
  assign o_credit_return_valid = r_credit_valid;
  assign o_credit_return_val   = r_credit_val;

  // dispatch side only spends credits it got back
  a_disp_fits : assert property (@(posedge i_clk) disable iff (i_reset_n)
    !i_flush |-> (w_disp_num <= w_free_cnt));

  a_one_finish : assert property (@(posedge i_clk) disable iff (i_reset_n)
    $onehot0(i_entry_finish));

endmodule

//--- rtl/ldq_entry_bank.sv
`timescale 1ns/1ps

module ldq_entry_bank (
  input  logic                          i_clk,
  input  logic                          i_reset_n,
  input  logic [ldq_pkg::DISP_SIZE-1:0] i_disp_valid,
  input  ldq_pkg::cmt_id_t              i_disp_cmt_id [ldq_pkg::DISP_SIZE],
  input  ldq_pkg::vaddr_t               i_disp_vaddr  [ldq_pkg::DISP_SIZE],
  input  ldq_pkg::ldq_idx_t             i_in_ptr,
  input  logic                          i_flush,
  input  ldq_pkg::ldq_oh_t              i_replay_oh,
  input  logic                          i_ex2_valid,
  input  ldq_pkg::ldq_idx_t             i_ex2_index,
  input  logic                          i_ex2_stq_haz,
  input  logic                          i_ex2_except,
  input  logic                          i_stq_resolve,
  input  ldq_pkg::ldq_oh_t              i_done_oh,
  input  logic                          i_commit_valid,
  input  ldq_pkg::cmt_id_t              i_commit_cmt_id,
  output ldq_pkg::ldq_oh_t              o_entry_valid,
  output ldq_pkg::ldq_oh_t              o_entry_ready,
  output ldq_pkg::ldq_oh_t              o_entry_done,
  output ldq_pkg::ldq_oh_t              o_entry_finish,
  output ldq_pkg::cmt_id_t              o_entry_cmt_id [ldq_pkg::LDQ_SIZE],
  output ldq_pkg::vaddr_t               o_entry_vaddr  [ldq_pkg::LDQ_SIZE],
  output ldq_pkg::ldq_oh_t              o_entry_except
);

  ldq_pkg::ldq_idx_t   w_slot_ptr [ldq_pkg::DISP_SIZE];
  ldq_pkg::ldq_state_t w_state    [ldq_pkg::LDQ_SIZE];
  ldq_pkg::ldq_oh_t    w_ex2_hit;
  ldq_pkg::ldq_oh_t    w_commit_match;

  // slot s lands at in_ptr + s
  for (genvar s = 0; s < ldq_pkg::DISP_SIZE; s++) begin : g_slot
    assign w_slot_ptr[s] = i_in_ptr + ldq_pkg::ldq_idx_t'(s);
  end

  // --------------------------------------------------------------------------
  // entries
  // --------------------------------------------------------------------------
  for (genvar e = 0; e < ldq_pkg::LDQ_SIZE; e++) begin : g_entry
    ldq_pkg::ldq_state_t          r_state;
    ldq_pkg::ldq_state_t          w_state_nxt;
    ldq_pkg::cmt_id_t             r_cmt_id;
    ldq_pkg::vaddr_t              r_vaddr;
    logic                         r_except;
    logic [ldq_pkg::DISP_SIZE-1:0] w_disp_hit;

    for (genvar s = 0; s < ldq_pkg::DISP_SIZE; s++) begin : g_hit
      assign w_disp_hit[s] = i_disp_valid[s] & !i_flush &
                             (w_slot_ptr[s] == ldq_pkg::ldq_idx_t'(e));
    end

    assign w_ex2_hit[e]      = i_ex2_valid & (i_ex2_index == ldq_pkg::ldq_idx_t'(e));
    assign w_commit_match[e] = i_commit_valid & (r_state != ldq_pkg::LDQ_INIT) &
                               (r_cmt_id == i_commit_cmt_id);

    always_comb begin
      w_state_nxt = r_state;
      unique case (r_state)
        ldq_pkg::LDQ_INIT: begin
          if (|w_disp_hit) w_state_nxt = ldq_pkg::LDQ_ISSUE_WAIT;
        end
        ldq_pkg::LDQ_ISSUE_WAIT: begin
          if (i_replay_oh[e]) w_state_nxt = ldq_pkg::LDQ_ISSUED;  // conflict already masked
        end
        ldq_pkg::LDQ_ISSUED: begin
          if (w_ex2_hit[e]) begin
            w_state_nxt = i_ex2_stq_haz ? ldq_pkg::LDQ_STQ_HAZ : ldq_pkg::LDQ_EX3_DONE;
          end
        end
        ldq_pkg::LDQ_STQ_HAZ: begin
          if (i_stq_resolve) w_state_nxt = ldq_pkg::LDQ_ISSUE_WAIT;
        end
        ldq_pkg::LDQ_EX3_DONE: begin
          if (i_done_oh[e]) w_state_nxt = ldq_pkg::LDQ_WAIT_COMPLETE;
        end
        ldq_pkg::LDQ_WAIT_COMPLETE: begin
          if (w_commit_match[e]) w_state_nxt = ldq_pkg::LDQ_INIT;
        end
        default: w_state_nxt = ldq_pkg::LDQ_INIT;
      endcase
    end

    always_ff @(posedge i_clk) begin
      if (i_reset_n) begin
        r_state <= ldq_pkg::LDQ_INIT;
      end else if (i_flush) begin
        r_state <= ldq_pkg::LDQ_INIT;  // kills in-flight loads as well
      end else begin
        r_state <= w_state_nxt;
      end
    end

    always_ff @(posedge i_clk) begin
      for (int s = 0; s < ldq_pkg::DISP_SIZE; s++) begin
        if (w_disp_hit[s]) begin
          r_cmt_id <= i_disp_cmt_id[s];
          r_vaddr  <= i_disp_vaddr[s];
        end
      end
      if (w_ex2_hit[e] && !i_ex2_stq_haz) r_except <= i_ex2_except;
    end

    assign w_state[e]        = r_state;
    assign o_entry_valid[e]  = (r_state != ldq_pkg::LDQ_INIT);
    assign o_entry_ready[e]  = (r_state == ldq_pkg::LDQ_ISSUE_WAIT);
    assign o_entry_done[e]   = (r_state == ldq_pkg::LDQ_EX3_DONE);
    assign o_entry_finish[e] = w_commit_match[e] & (r_state == ldq_pkg::LDQ_WAIT_COMPLETE);
    assign o_entry_cmt_id[e] = r_cmt_id;
    assign o_entry_vaddr[e]  = r_vaddr;
    assign o_entry_except[e] = r_except;
  end

  // pipeline only reports on loads it was handed
  a_ex2_on_issued : assert property (@(posedge i_clk) disable iff (i_reset_n)
    i_ex2_valid |-> (w_state[i_ex2_index] == ldq_pkg::LDQ_ISSUED));

  // cmt_id is unique among live loads
  a_commit_unique : assert property (@(posedge i_clk) disable iff (i_reset_n)
    $onehot0(w_commit_match));

endmodule

//--- rtl/ldq_pick.sv
`timescale 1ns/1ps

module ldq_pick (
  input  ldq_pkg::ldq_idx_t i_out_ptr,
  input  ldq_pkg::ldq_oh_t  i_entry_ready,
  input  ldq_pkg::ldq_oh_t  i_entry_done,
  input  ldq_pkg::cmt_id_t  i_entry_cmt_id [ldq_pkg::LDQ_SIZE],
  input  ldq_pkg::vaddr_t   i_entry_vaddr  [ldq_pkg::LDQ_SIZE],
  input  ldq_pkg::ldq_oh_t  i_entry_except,
  input  logic              i_replay_conflict,
  output logic              o_replay_valid,
  output ldq_pkg::ldq_idx_t o_replay_index,
  output ldq_pkg::cmt_id_t  o_replay_cmt_id,
  output ldq_pkg::vaddr_t   o_replay_vaddr,
  output ldq_pkg::ldq_oh_t  o_replay_oh,
  output logic              o_done_valid,
  output ldq_pkg::cmt_id_t  o_done_cmt_id,
  output logic              o_done_except,
  output ldq_pkg::ldq_oh_t  o_done_oh
);

  ldq_pkg::ldq_oh_t w_replay_sel;
  ldq_pkg::ldq_oh_t w_done_sel;

  // rotate so out_ptr sits at bit 0, take lowest set bit, rotate back
  function automatic ldq_pkg::ldq_oh_t oldest_oh(input ldq_pkg::ldq_oh_t  mask,
                                                 input ldq_pkg::ldq_idx_t ptr);
    ldq_pkg::ldq_oh_t rot;
    ldq_pkg::ldq_oh_t rot_lsb;
    rot     = (mask >> ptr) | (mask << (ldq_pkg::LDQ_SIZE - int'(ptr)));
    rot_lsb = rot & (~rot + ldq_pkg::ldq_oh_t'(1));
    return (rot_lsb << ptr) | (rot_lsb >> (ldq_pkg::LDQ_SIZE - int'(ptr)));
  endfunction

  assign w_replay_sel = oldest_oh(i_entry_ready, i_out_ptr);
  assign w_done_sel   = oldest_oh(i_entry_done, i_out_ptr);

  // --------------------------------------------------------------------------
  // replay port
  // --------------------------------------------------------------------------
  assign o_replay_valid = |i_entry_ready;
  assign o_replay_oh    = i_replay_conflict ? '0 : w_replay_sel;  // pick cancelled

  always_comb begin
    o_replay_index  = '0;
    o_replay_cmt_id = '0;
    o_replay_vaddr  = '0;
    for (int e = 0; e < ldq_pkg::LDQ_SIZE; e++) begin
      if (w_replay_sel[e]) begin
        o_replay_index  = ldq_pkg::ldq_idx_t'(e);
        o_replay_cmt_id = i_entry_cmt_id[e];
        o_replay_vaddr  = i_entry_vaddr[e];
      end
    end
  end

  // --------------------------------------------------------------------------
  // done report, no back-pressure
  // --------------------------------------------------------------------------
  assign o_done_valid = |i_entry_done;
  assign o_done_oh    = w_done_sel;

  always_comb begin
    o_done_cmt_id = '0;
    o_done_except = 1'b0;
    for (int e = 0; e < ldq_pkg::LDQ_SIZE; e++) begin
      if (w_done_sel[e]) begin
        o_done_cmt_id = i_entry_cmt_id[e];
        o_done_except = i_entry_except[e];
      end
    end
  end

endmodule

//--- rtl/ldq_top.sv
`timescale 1ns/1ps

module ldq_top (
  input  logic                          i_clk,
  input  logic                          i_reset_n,
  // dispatch
  input  logic [ldq_pkg::DISP_SIZE-1:0] i_disp_valid,
  input  ldq_pkg::cmt_id_t              i_disp_cmt_id [ldq_pkg::DISP_SIZE],
  input  ldq_pkg::vaddr_t               i_disp_vaddr  [ldq_pkg::DISP_SIZE],
  // issue / replay
  output logic                          o_replay_valid,
  output ldq_pkg::ldq_idx_t             o_replay_index,
  output ldq_pkg::cmt_id_t              o_replay_cmt_id,
  output ldq_pkg::vaddr_t               o_replay_vaddr,
  input  logic                          i_replay_conflict,
  // ex2 result
  input  logic                          i_ex2_valid,
  input  ldq_pkg::ldq_idx_t             i_ex2_index,
  input  logic                          i_ex2_stq_haz,
  input  logic                          i_ex2_except,
  input  logic                          i_stq_resolve,
  // done report
  output logic                          o_done_valid,
  output ldq_pkg::cmt_id_t              o_done_cmt_id,
  output logic                          o_done_except,
  // commit
  input  logic                          i_commit_valid,
  input  ldq_pkg::cmt_id_t              i_commit_cmt_id,
  input  logic                          i_flush,
  // credits back to dispatch
  output logic                          o_credit_return_valid,
  output ldq_pkg::ldq_cnt_t             o_credit_return_val
);

  ldq_pkg::ldq_oh_t  w_entry_valid;
  ldq_pkg::ldq_oh_t  w_entry_ready;
  ldq_pkg::ldq_oh_t  w_entry_done;
  ldq_pkg::ldq_oh_t  w_entry_finish;
  ldq_pkg::ldq_oh_t  w_entry_except;
  ldq_pkg::cmt_id_t  w_entry_cmt_id [ldq_pkg::LDQ_SIZE];
  ldq_pkg::vaddr_t   w_entry_vaddr  [ldq_pkg::LDQ_SIZE];
  ldq_pkg::ldq_idx_t w_in_ptr;
  ldq_pkg::ldq_idx_t w_out_ptr;
  ldq_pkg::ldq_oh_t  w_replay_oh;
  ldq_pkg::ldq_oh_t  w_done_oh;

  ldq_alloc u_ldq_alloc (
    .i_clk                 (i_clk),
    .i_reset_n             (i_reset_n),
    .i_disp_valid          (i_disp_valid),
    .i_flush               (i_flush),
    .i_entry_valid         (w_entry_valid),
    .i_entry_finish        (w_entry_finish),
    .o_in_ptr              (w_in_ptr),
    .o_out_ptr             (w_out_ptr),
    .o_credit_return_valid (o_credit_return_valid),
    .o_credit_return_val   (o_credit_return_val)
  );

  ldq_entry_bank u_ldq_entry_bank (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_disp_valid    (i_disp_valid),
    .i_disp_cmt_id   (i_disp_cmt_id),
    .i_disp_vaddr    (i_disp_vaddr),
    .i_in_ptr        (w_in_ptr),
    .i_flush         (i_flush),
    .i_replay_oh     (w_replay_oh),
    .i_ex2_valid     (i_ex2_valid),
    .i_ex2_index     (i_ex2_index),
    .i_ex2_stq_haz   (i_ex2_stq_haz),
    .i_ex2_except    (i_ex2_except),
    .i_stq_resolve   (i_stq_resolve),
    .i_done_oh       (w_done_oh),
    .i_commit_valid  (i_commit_valid),
    .i_commit_cmt_id (i_commit_cmt_id),
    .o_entry_valid   (w_entry_valid),
    .o_entry_ready   (w_entry_ready),
    .o_entry_done    (w_entry_done),
    .o_entry_finish  (w_entry_finish),
    .o_entry_cmt_id  (w_entry_cmt_id),
    .o_entry_vaddr   (w_entry_vaddr),
    .o_entry_except  (w_entry_except)
  );

  ldq_pick u_ldq_pick (
    .i_out_ptr         (w_out_ptr),
    .i_entry_ready     (w_entry_ready),
    .i_entry_done      (w_entry_done),
    .i_entry_cmt_id    (w_entry_cmt_id),
    .i_entry_vaddr     (w_entry_vaddr),
    .i_entry_except    (w_entry_except),
    .i_replay_conflict (i_replay_conflict),
    .o_replay_valid    (o_replay_valid),
    .o_replay_index    (o_replay_index),
    .o_replay_cmt_id   (o_replay_cmt_id),
    .o_replay_vaddr    (o_replay_vaddr),
    .o_replay_oh       (w_replay_oh),
    .o_done_valid      (o_done_valid),
    .o_done_cmt_id     (o_done_cmt_id),
    .o_done_except     (o_done_except),
    .o_done_oh         (w_done_oh)
  );

endmodule

//--- tb/ldq_tb.sv
`timescale 1ns/1ps

module ldq_tb;

  localparam int MAX_CYCLES = 200;
  localparam int IDLE_WAIT  = 16;
  localparam int MAX_LINES  = 100;

  logic                          i_clk = 1'b0;
  logic                          i_reset_n;
  logic [ldq_pkg::DISP_SIZE-1:0] i_disp_valid;
  ldq_pkg::cmt_id_t              i_disp_cmt_id [ldq_pkg::DISP_SIZE];
  ldq_pkg::vaddr_t               i_disp_vaddr  [ldq_pkg::DISP_SIZE];
  logic                          o_replay_valid;
  ldq_pkg::ldq_idx_t             o_replay_index;
  ldq_pkg::cmt_id_t              o_replay_cmt_id;
  ldq_pkg::vaddr_t               o_replay_vaddr;
  logic                          i_replay_conflict;
  logic                          i_ex2_valid;
  ldq_pkg::ldq_idx_t             i_ex2_index;
  logic                          i_ex2_stq_haz;
  logic                          i_ex2_except;
  logic                          i_stq_resolve;
  logic                          o_done_valid;
  ldq_pkg::cmt_id_t              o_done_cmt_id;
  logic                          o_done_except;
  logic                          i_commit_valid;
  ldq_pkg::cmt_id_t              i_commit_cmt_id;
  logic                          i_flush;
  logic                          o_credit_return_valid;
  ldq_pkg::ldq_cnt_t             o_credit_return_val;

  int               err_cnt   = 0;
  int               chk_cnt   = 0;
  int               cycle_cnt = 0;
  int               fd;
  int               n_tok;
  int               wait_cnt;
  int               line_cnt;
  logic [8*256-1:0] line_buf;
  logic [8*16-1:0]  tname;
  logic [31:0]      v [23];    // 14 inputs then 9 expected outputs

  always #10 i_clk = ~i_clk;

  ldq_top ldq_top_inst (.*);

  // run limit
  always @(posedge i_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout, run did not end within %0d cycles", MAX_CYCLES);
      $display("%0d checks, %0d errors", chk_cnt, err_cnt + 1);
      $display("Errors found");
      $finish;
    end
  end

  task automatic mismatch(input logic [8*16-1:0] test, input string sig,
                          input logic [31:0] exp, input logic [31:0] act);
    err_cnt++;
    $display("ERR %0s %s expected %h actual %h", test, sig, exp, act);
  endtask

  task automatic apply_inputs;
    i_disp_valid      = v[0][1:0];
    i_disp_cmt_id[0]  = v[1][5:0];
    i_disp_vaddr[0]   = v[2][15:0];
    i_disp_cmt_id[1]  = v[3][5:0];
    i_disp_vaddr[1]   = v[4][15:0];
    i_replay_conflict = v[5][0];
    i_ex2_valid       = v[6][0];
    i_ex2_index       = v[7][2:0];
    i_ex2_stq_haz     = v[8][0];
    i_ex2_except      = v[9][0];
    i_stq_resolve     = v[10][0];
    i_commit_valid    = v[11][0];
    i_commit_cmt_id   = v[12][5:0];
    i_flush           = v[13][0];
  endtask

  task automatic check_outputs;
    chk_cnt++;
    if (o_replay_valid !== v[14][0]) mismatch(tname, "replay_valid", v[14], 32'(o_replay_valid));
    if (o_replay_index !== v[15][2:0]) mismatch(tname, "replay_index", v[15], 32'(o_replay_index));
    if (o_replay_cmt_id !== v[16][5:0]) mismatch(tname, "replay_cmt_id", v[16], 32'(o_replay_cmt_id));
    if (o_replay_vaddr !== v[17][15:0]) mismatch(tname, "replay_vaddr", v[17], 32'(o_replay_vaddr));
    if (o_done_valid !== v[18][0]) mismatch(tname, "done_valid", v[18], 32'(o_done_valid));
    if (o_done_cmt_id !== v[19][5:0]) mismatch(tname, "done_cmt_id", v[19], 32'(o_done_cmt_id));
    if (o_done_except !== v[20][0]) mismatch(tname, "done_except", v[20], 32'(o_done_except));
    if (o_credit_return_valid !== v[21][0]) begin
      mismatch(tname, "credit_valid", v[21], 32'(o_credit_return_valid));
    end
    if (o_credit_return_val !== v[22][3:0]) begin
      mismatch(tname, "credit_val", v[22], 32'(o_credit_return_val));
    end
  endtask

  // one stimulus line = one clock cycle
  task automatic run_cycle;
    @(negedge i_clk);
    apply_inputs();
    #5;               // outputs settled, well before the next rising edge
    check_outputs();
  endtask

  initial begin
    foreach (v[k]) v[k] = '0;
    apply_inputs();
    i_reset_n = 1'b1;
    repeat (8) @(posedge i_clk);
    @(negedge i_clk);
    i_reset_n = 1'b0;

    wait_cnt = 0;
    while ((o_replay_valid || o_done_valid || o_credit_return_valid) && wait_cnt < IDLE_WAIT) begin
      @(negedge i_clk);
      wait_cnt++;
    end
    if (wait_cnt >= IDLE_WAIT) begin
      err_cnt++;
      $display("replay, done or credit output still active after reset");
    end

    // --------------------------------------------------------------------------
    // stimulus file
    // --------------------------------------------------------------------------
    fd = $fopen("tb/ldq_stimulus.txt", "r");
    if (fd == 0) begin
      err_cnt++;
      $display("could not open tb/ldq_stimulus.txt");
    end else begin
      line_cnt = 0;
      while (!$feof(fd) && line_cnt < MAX_LINES) begin
        line_buf = '0;
        tname    = '0;
        if ($fgets(line_buf, fd) != 0) begin
          n_tok = $sscanf(line_buf,
                          "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                          tname, v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9],
                          v[10], v[11], v[12], v[13], v[14], v[15], v[16], v[17], v[18],
                          v[19], v[20], v[21], v[22]);
          if (n_tok > 0 && tname[7:0] != "#") begin
            line_cnt++;
            if (n_tok != 24) begin
              err_cnt++;
              $display("stimulus line %0d has %0d fields instead of 24", line_cnt, n_tok);
            end else begin
              run_cycle();
            end
          end
        end
      end
      $fclose(fd);
      if (line_cnt == 0) begin
        err_cnt++;
        $display("stimulus file holds no data lines");
      end
    end

    $display("%0d checks, %0d errors", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- tb/ldq_stimulus.txt
# in:  name dv c0 a0 c1 a1 cf(conflict) xv xi xh xe(ex2) rs(resolve) cv cid(commit) fl(flush)
# out: rv ri rc ra(replay) dv dc de(done) kv kn(credit), all values hex
rst       0 00 0000 00 0000 0 0 0 0 0 0 0 00 0  0 0 00 0000 0 00 0 0 0
disp2     3 01 1000 02 2000 0 0 0 0 0 0 0 00 0  0 0 00 0000 0 00 0 0 0
offer     1 03 3000 00 0000 1 0 0 0 0 0 0 00 0  1 0 01 1000 0 00 0 0 0
conflict  0 00 0000 00 0000 1 0 0 0 0 0 0 00 0  1 0 01 1000 0 00 0 0 0
oldest0   0 00 0000 00 0000 0 0 0 0 0 0 0 00 0  1 0 01 1000 0 00 0 0 0
oldest1   0 00 0000 00 0000 0 1 0 0 1 0 0 00 0  1 1 02 2000 0 00 0 0 0
done0     0 00 0000 00 0000 0 1 1 1 0 0 0 00 0  1 2 03 3000 1 01 1 0 0
hazard    0 00 0000 00 0000 0 1 2 0 0 0 0 00 0  0 0 00 0000 0 00 0 0 0
done2     0 00 0000 00 0000 0 0 0 0 0 0 1 01 0  0 0 00 0000 1 03 0 0 0
credit0   0 00 0000 00 0000 0 0 0 0 0 1 0 00 0  0 0 00 0000 0 00 0 1 1
resolve   0 00 0000 00 0000 0 0 0 0 0 0 0 00 0  1 1 02 2000 0 00 0 0 0
reissue   0 00 0000 00 0000 0 1 1 0 0 0 0 00 0  0 0 00 0000 0 00 0 0 0
done1     0 00 0000 00 0000 0 0 0 0 0 0 0 00 0  0 0 00 0000 1 02 0 0 0
commit1   0 00 0000 00 0000 0 0 0 0 0 0 1 02 0  0 0 00 0000 0 00 0 0 0
commit2   0 00 0000 00 0000 0 0 0 0 0 0 1 03 0  0 0 00 0000 0 00 0 1 1
wrap_a    3 04 4004 05 4005 1 0 0 0 0 0 0 00 0  0 0 00 0000 0 00 0 1 1
wrap_b    3 06 4006 07 4007 1 0 0 0 0 0 0 00 0  1 3 04 4004 0 00 0 0 0
wrap_c    3 08 4008 09 4009 1 0 0 0 0 0 0 00 0  1 3 04 4004 0 00 0 0 0
issue3    0 00 0000 00 0000 0 0 0 0 0 0 0 00 0  1 3 04 4004 0 00 0 0 0
issue4    0 00 0000 00 0000 0 1 3 0 1 0 0 00 0  1 4 05 4005 0 00 0 0 0
issue5    0 00 0000 00 0000 0 1 4 1 0 0 0 00 0  1 5 06 4006 1 04 1 0 0
issue6    0 00 0000 00 0000 0 0 0 0 0 0 1 04 0  1 6 07 4007 0 00 0 0 0
issue7    0 00 0000 00 0000 0 0 0 0 0 0 0 00 0  1 7 08 4008 0 00 0 1 1
issue0    1 0a 400a 00 0000 1 0 0 0 0 0 0 00 0  1 0 09 4009 0 00 0 0 0
flush     1 0b 400b 00 0000 0 0 0 0 0 0 0 00 1  1 0 09 4009 0 00 0 0 0
flush_cr  0 00 0000 00 0000 0 0 0 0 0 0 0 00 0  0 0 00 0000 0 00 0 1 6
idle      1 0c 400c 00 0000 0 0 0 0 0 0 0 00 0  0 0 00 0000 0 00 0 0 0
redisp    0 00 0000 00 0000 0 0 0 0 0 0 0 00 0  1 4 0c 400c 0 00 0 0 0
quiet     0 00 0000 00 0000 0 0 0 0 0 0 0 00 0  0 0 00 0000 0 00 0 0 0

//--- vlog.f
rtl/ldq_pkg.sv
rtl/ldq_alloc.sv
rtl/ldq_entry_bank.sv
rtl/ldq_pick.sv
rtl/ldq_top.sv
tb/ldq_tb.sv

//--- Makefile
VERILATOR  = verilator
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing --assert
TOP        = ldq_tb
FILELIST   = vlog.f
OBJ_DIR    = obj_dir
SIM_EXE    = $(OBJ_DIR)/V$(TOP)
LOG        = sim.log
FAIL_MSG   = Errors found

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_EXE): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(SIM_EXE)
	./$(SIM_EXE) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation FAILED"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
